//--- verilog/alu_other_defines.svh
`ifndef ALU_OTHER_DEFINES_SVH
`define ALU_OTHER_DEFINES_SVH

// vector register and scalar widths
`define VLEN 128
`define VLENB (`VLEN/`BYTE_WIDTH)
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// uop bookkeeping
`define ROB_IDX_WIDTH 4
`define UOP_INDEX_WIDTH 3

`endif

//--- verilog/alu_other_pkg.sv
`include "alu_other_defines.svh"

package alu_other_pkg;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // vs1 field under VXUNARY0
  typedef enum logic [4:0] {
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } ext_sel_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MINU,
    OP_MIN,
    OP_MAXU,
    OP_MAX,
    OP_MOVE,
    OP_MERGE,
    OP_ZEXT2,
    OP_SEXT2,
    OP_ZEXT4,
    OP_SEXT4
  } alu_op_e;

  typedef struct packed {
    logic [`ROB_IDX_WIDTH-1:0]   rob_entry;
    funct3_e                     funct3;
    funct6_e                     funct6;
    logic [4:0]                  vs1;
    logic                        vm;
    eew_e                        vd_eew;
    eew_e                        vs2_eew;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic [`VLEN-1:0]            v0_data;
    logic [`VLEN-1:0]            vs1_data;
    logic [`VLEN-1:0]            vs2_data;
    logic [`XLEN-1:0]            rs1_data;
  } alu_uop_t;

  typedef struct packed {
    logic [`ROB_IDX_WIDTH-1:0] rob_entry;
    logic [`VLEN-1:0]          w_data;
    logic                      ignore_vma;
  } alu_result_t;

endpackage

//--- verilog/alu_other_ctrl.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_other_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  output logic                       uop_ready,
  input  alu_other_pkg::alu_uop_t    uop,
  output logic                       result_valid,
  input  logic                       result_ready,
  output alu_other_pkg::alu_result_t result,
  output alu_other_pkg::alu_op_e     op,
  output alu_other_pkg::eew_e        op_eew,
  input  logic [`VLEN-1:0]           minmax_data,
  input  logic [`VLEN-1:0]           merge_data,
  input  logic [`VLEN-1:0]           extend_data,
  input  logic [`VLEN-1:0]           move_data
);
  import alu_other_pkg::*;

  logic             load;
  logic [`VLEN-1:0] sel_data;

  always_comb begin
    op = OP_NONE;
    case (uop.funct3)
      OPIVV, OPIVX: begin
        case (uop.funct6)
          VMINU:      op = OP_MINU;
          VMIN:       op = OP_MIN;
          VMAXU:      op = OP_MAXU;
          VMAX:       op = OP_MAX;
          VMERGE_VMV: op = uop.vm ? OP_MOVE : OP_MERGE;
          default:    op = OP_NONE;
        endcase
      end
      // no min/max in immediate form
      OPIVI: begin
        if (uop.funct6 == VMERGE_VMV) begin
          op = uop.vm ? OP_MOVE : OP_MERGE;
        end
      end
      OPMVV: begin
        if (uop.funct6 == VXUNARY0) begin
          case (uop.vs1)
            VZEXT_VF2: op = OP_ZEXT2;
            VSEXT_VF2: op = OP_SEXT2;
            VZEXT_VF4: op = OP_ZEXT4;
            VSEXT_VF4: op = OP_SEXT4;
            default:   op = OP_NONE;
          endcase
        end
      end
      default: op = OP_NONE;
    endcase
  end

  assign op_eew = (op == OP_MOVE) ? uop.vd_eew : uop.vs2_eew;

  always_comb begin
    case (op)
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX:     sel_data = minmax_data;
      OP_MOVE:                              sel_data = move_data;
      OP_MERGE:                             sel_data = merge_data;
      OP_ZEXT2, OP_SEXT2, OP_ZEXT4, OP_SEXT4: sel_data = extend_data;
      default:                              sel_data = '0;
    endcase
  end

  // output register, refilled in the same cycle it drains
  assign uop_ready = !result_valid || result_ready;
  assign load      = uop_valid && uop_ready && (op != OP_NONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (load) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result.rob_entry  <= uop.rob_entry;
      result.w_data     <= sel_data;
      result.ignore_vma <= (op == OP_MERGE);
    end
  end

  a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result));

  // vf4 only exists for byte sources
  a_vf4_eew: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid && (op == OP_ZEXT4 || op == OP_SEXT4) |-> uop.vs2_eew == EEW8);

endmodule

//--- verilog/alu_operand_prep.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_operand_prep (
  input  alu_other_pkg::alu_uop_t uop,
  input  alu_other_pkg::eew_e     op_eew,
  output logic [`VLEN-1:0]        src1,
  output logic [`VLENB-1:0]       mask_slice
);
  import alu_other_pkg::*;

  logic [`VLEN-1:0] rs1_bcast;
  logic [`VLEN-1:0] v0_shift;

  // scalar replicated at the operand width
  always_comb begin
    case (op_eew)
      EEW8:    rs1_bcast = {`VLENB{uop.rs1_data[`BYTE_WIDTH-1:0]}};
      EEW16:   rs1_bcast = {(`VLEN/`HWORD_WIDTH){uop.rs1_data[`HWORD_WIDTH-1:0]}};
      EEW32:   rs1_bcast = {(`VLEN/`WORD_WIDTH){uop.rs1_data[`WORD_WIDTH-1:0]}};
      default: rs1_bcast = '0;
    endcase
  end

  always_comb begin
    case (uop.funct3)
      OPIVV:        src1 = uop.vs1_data;
      OPIVX, OPIVI: src1 = rs1_bcast;
      default:      src1 = '0;
    endcase
  end

  // one mask bit per element, so the slice base scales with elements per register
  always_comb begin
    case (op_eew)
      EEW8:    v0_shift = uop.v0_data >> (uop.uop_index * `VLENB);
      EEW16:   v0_shift = uop.v0_data >> (uop.uop_index * (`VLEN/`HWORD_WIDTH));
      EEW32:   v0_shift = uop.v0_data >> (uop.uop_index * (`VLEN/`WORD_WIDTH));
      default: v0_shift = '0;
    endcase
  end

  assign mask_slice = v0_shift[`VLENB-1:0];

endmodule

//--- verilog/alu_minmax.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_minmax (
  input  alu_other_pkg::alu_op_e op,
  input  alu_other_pkg::eew_e    eew,
  input  logic [`VLEN-1:0]       src2,
  input  logic [`VLEN-1:0]       src1,
  output logic [`VLEN-1:0]       data
);
  import alu_other_pkg::*;

  logic                  is_signed;
  logic                  is_min;
  logic                  active;
  logic [2:0][`VLEN-1:0] lane_data;

  assign is_signed = (op == OP_MIN) || (op == OP_MAX);
  assign is_min    = (op == OP_MINU) || (op == OP_MIN);
  assign active    = is_min || (op == OP_MAXU) || (op == OP_MAX);

  // lanes at 8, 16 and 32 bits
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = (w == 0) ? `BYTE_WIDTH : (w == 1) ? `HWORD_WIDTH : `WORD_WIDTH;

    for (genvar k = 0; k < `VLEN/EW; k++) begin : g_lane
      logic signed [EW:0] a;
      logic signed [EW:0] b;
      logic               lt;

      // extra top bit: sign for signed ops, zero for unsigned
      assign a  = {is_signed & src2[k*EW+EW-1], src2[k*EW +: EW]};
      assign b  = {is_signed & src1[k*EW+EW-1], src1[k*EW +: EW]};
      assign lt = a < b;

      assign lane_data[w][k*EW +: EW] = (lt == is_min) ? src2[k*EW +: EW] : src1[k*EW +: EW];
    end
  end

  always_comb begin
    data = '0;
    if (active) begin
      case (eew)
        EEW8:    data = lane_data[0];
        EEW16:   data = lane_data[1];
        EEW32:   data = lane_data[2];
        default: data = '0;
      endcase
    end
  end

endmodule

//--- verilog/alu_extend.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_extend (
  input  alu_other_pkg::alu_op_e       op,
  input  alu_other_pkg::eew_e          eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [`VLEN-1:0]             src2,
  output logic [`VLEN-1:0]             data
);
  import alu_other_pkg::*;

  logic [`VLEN/2-1:0] half;
  logic [`VLEN/4-1:0] quarter;
  logic               sext;

  // source part for this uop
  assign half    = uop_index[0] ? src2[`VLEN/2 +: `VLEN/2] : src2[0 +: `VLEN/2];
  assign quarter = src2[uop_index[1:0]*(`VLEN/4) +: `VLEN/4];
  assign sext    = (op == OP_SEXT2) || (op == OP_SEXT4);

  always_comb begin
    data = '0;
    case (op)
      OP_ZEXT2, OP_SEXT2: begin
        if (eew == EEW8) begin
          for (int k = 0; k < `VLEN/`HWORD_WIDTH; k++) begin
            data[k*`HWORD_WIDTH +: `HWORD_WIDTH] =
              {{`BYTE_WIDTH{sext & half[k*`BYTE_WIDTH+`BYTE_WIDTH-1]}},
               half[k*`BYTE_WIDTH +: `BYTE_WIDTH]};
          end
        end else if (eew == EEW16) begin
          for (int k = 0; k < `VLEN/`WORD_WIDTH; k++) begin
            data[k*`WORD_WIDTH +: `WORD_WIDTH] =
              {{`HWORD_WIDTH{sext & half[k*`HWORD_WIDTH+`HWORD_WIDTH-1]}},
               half[k*`HWORD_WIDTH +: `HWORD_WIDTH]};
          end
        end
      end
      OP_ZEXT4, OP_SEXT4: begin
        if (eew == EEW8) begin
          for (int k = 0; k < `VLEN/`WORD_WIDTH; k++) begin
            data[k*`WORD_WIDTH +: `WORD_WIDTH] =
              {{(`WORD_WIDTH-`BYTE_WIDTH){sext & quarter[k*`BYTE_WIDTH+`BYTE_WIDTH-1]}},
               quarter[k*`BYTE_WIDTH +: `BYTE_WIDTH]};
          end
        end
      end
      default: data = '0;
    endcase
  end

endmodule

//--- verilog/alu_merge.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_merge (
  input  alu_other_pkg::eew_e  eew,
  input  logic [`VLENB-1:0]    mask_slice,
  input  logic [`VLEN-1:0]     src2,
  input  logic [`VLEN-1:0]     src1,
  output logic [`VLEN-1:0]     data
);
  import alu_other_pkg::*;

  // mask bit k picks src1 for element k
  always_comb begin
    data = src2;
    case (eew)
      EEW8: begin
        for (int k = 0; k < `VLENB; k++) begin
          if (mask_slice[k]) data[k*`BYTE_WIDTH +: `BYTE_WIDTH] = src1[k*`BYTE_WIDTH +: `BYTE_WIDTH];
        end
      end
      EEW16: begin
        for (int k = 0; k < `VLEN/`HWORD_WIDTH; k++) begin
          if (mask_slice[k]) data[k*`HWORD_WIDTH +: `HWORD_WIDTH] = src1[k*`HWORD_WIDTH +: `HWORD_WIDTH];
        end
      end
      EEW32: begin
        for (int k = 0; k < `VLEN/`WORD_WIDTH; k++) begin
          if (mask_slice[k]) data[k*`WORD_WIDTH +: `WORD_WIDTH] = src1[k*`WORD_WIDTH +: `WORD_WIDTH];
        end
      end
      default: data = '0;
    endcase
  end

endmodule

//--- verilog/alu_other_top.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module alu_other_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  output logic                       uop_ready,
  input  alu_other_pkg::alu_uop_t    uop,
  output logic                       result_valid,
  input  logic                       result_ready,
  output alu_other_pkg::alu_result_t result
);
  import alu_other_pkg::*;

  alu_op_e           op;
  eew_e              op_eew;
  logic [`VLEN-1:0]  src1;
  logic [`VLENB-1:0] mask_slice;
  logic [`VLEN-1:0]  minmax_data;
  logic [`VLEN-1:0]  merge_data;
  logic [`VLEN-1:0]  extend_data;

  alu_other_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .uop          (uop),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result),
    .op           (op),
    .op_eew       (op_eew),
    .minmax_data  (minmax_data),
    .merge_data   (merge_data),
    .extend_data  (extend_data),
    .move_data    (src1)
  );

  alu_operand_prep u_prep (
    .uop        (uop),
    .op_eew     (op_eew),
    .src1       (src1),
    .mask_slice (mask_slice)
  );

  alu_minmax u_minmax (
    .op   (op),
    .eew  (op_eew),
    .src2 (uop.vs2_data),
    .src1 (src1),
    .data (minmax_data)
  );

  alu_extend u_extend (
    .op        (op),
    .eew       (op_eew),
    .uop_index (uop.uop_index),
    .src2      (uop.vs2_data),
    .data      (extend_data)
  );

  alu_merge u_merge (
    .eew        (op_eew),
    .mask_slice (mask_slice),
    .src2       (uop.vs2_data),
    .src1       (src1),
    .data       (merge_data)
  );

endmodule

//--- sim/tb_alu_other.sv
`timescale 1ns/1ps
`include "alu_other_defines.svh"

module tb_alu_other;
  import alu_other_pkg::*;

  localparam int MAX_TESTS = 64;

  logic        clk;
  logic        rst_n;
  logic        uop_valid;
  logic        uop_ready;
  alu_uop_t    uop;
  logic        result_valid;
  logic        result_ready;
  alu_result_t result;

  alu_uop_t         test_uop  [MAX_TESTS];
  logic [`VLEN-1:0] test_data [MAX_TESTS];
  logic             test_vma  [MAX_TESTS];
  logic             test_none [MAX_TESTS];
  string            test_name [MAX_TESTS];
  int               num_tests;

  // test indices of accepted uops still owed a result
  int          exp_queue[$];
  int          current_idx;
  int          errors;
  int          checked;
  int          cycles;
  int          timeout_limit;
  logic [31:0] rng_state;
  alu_result_t held;
  logic        held_valid;
  logic        result_due;

  alu_other_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .uop          (uop),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_tests();
    int               fd;
    int               n;
    string            line;
    string            name;
    string            exp_str;
    logic [`VLEN-1:0] fld [0:12];
    alu_uop_t         u;
    fd = $fopen("sim/alu_other_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file sim/alu_other_testdata.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %s %h", name,
                  fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                  fld[8], fld[9], fld[10], fld[11], exp_str, fld[12]);
      if (n != 15 || num_tests >= MAX_TESTS) begin
        $display("test data line could not be read: %s", line);
        errors++;
        continue;
      end
      u = '0;
      u.rob_entry = fld[0][`ROB_IDX_WIDTH-1:0];
      u.funct3    = funct3_e'(fld[1][2:0]);
      u.funct6    = funct6_e'(fld[2][5:0]);
      u.vs1       = fld[3][4:0];
      u.vm        = fld[4][0];
      u.vd_eew    = eew_e'(fld[5][1:0]);
      u.vs2_eew   = eew_e'(fld[6][1:0]);
      u.uop_index = fld[7][`UOP_INDEX_WIDTH-1:0];
      u.v0_data   = fld[8];
      u.vs1_data  = fld[9];
      u.vs2_data  = fld[10];
      u.rs1_data  = fld[11][`XLEN-1:0];
      test_uop[num_tests]  = u;
      test_name[num_tests] = name;
      test_none[num_tests] = (exp_str == "NONE");
      test_vma[num_tests]  = fld[12][0];
      test_data[num_tests] = '0;
      if (exp_str != "NONE") begin
        void'($sscanf(exp_str, "%h", test_data[num_tests]));
      end
      num_tests++;
    end
    $fclose(fd);
  endtask

  task automatic send_uop(input int idx);
    logic fire;
    current_idx = idx;
    uop         = test_uop[idx];
    uop_valid   = 1'b1;
    fire        = 1'b0;
    while (!fire) begin
      @(negedge clk);
      fire = uop_valid && uop_ready;
      @(posedge clk);
      #1;
    end
    uop_valid = 1'b0;
  endtask

  task automatic check_result(input int idx);
    assert (result.w_data == test_data[idx]) else begin
      $display("[ERROR] %s: expected w_data %h, actual %h",
               test_name[idx], test_data[idx], result.w_data);
      errors++;
    end
    assert (result.ignore_vma == test_vma[idx]) else begin
      $display("[ERROR] %s: expected ignore_vma %0b, actual %0b",
               test_name[idx], test_vma[idx], result.ignore_vma);
      errors++;
    end
    assert (result.rob_entry == test_uop[idx].rob_entry) else begin
      $display("[ERROR] %s: expected rob_entry %h, actual %h",
               test_name[idx], test_uop[idx].rob_entry, result.rob_entry);
      errors++;
    end
  endtask

  task automatic finish_run();
    if (exp_queue.size() != 0) begin
      $display("%0d expected results never arrived", exp_queue.size());
      errors++;
    end
    $display("checked %0d results, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // random back-pressure with about three ready cycles in four
  initial begin
    rng_state    = 32'h01400025;
    result_ready = 1'b1;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      rng_state    = xorshift32(rng_state);
      result_ready = (rng_state[1:0] != 2'b00);
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    int idx;
    if (rst_n) begin
      assert (uop_ready == (!result_valid || result_ready)) else begin
        $display("uop_ready is %0b although result_valid is %0b and result_ready is %0b",
                 uop_ready, result_valid, result_ready);
        errors++;
      end
      if (result_due) begin
        assert (result_valid) else begin
          $display("no result one cycle after an accepted uop");
          errors++;
        end
      end
      if (held_valid) begin
        assert (result_valid) else begin
          $display("result_valid dropped before the result was taken");
          errors++;
        end
        if (result_valid) begin
          assert (result == held) else begin
            $display("result changed while waiting for result_ready");
            errors++;
          end
        end
      end
      if (result_valid && result_ready) begin
        held_valid = 1'b0;
        if (exp_queue.size() == 0) begin
          $display("a result arrived while no result was expected");
          errors++;
        end else begin
          idx = exp_queue.pop_front();
          checked++;
          check_result(idx);
        end
      end else begin
        held       = result;
        held_valid = result_valid;
      end
      result_due = uop_valid && uop_ready && !test_none[current_idx];
      if (result_due) begin
        exp_queue.push_back(current_idx);
      end
    end
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      errors++;
      finish_run();
    end
  end

  initial begin
    rst_n         = 1'b0;
    uop_valid     = 1'b0;
    uop           = '0;
    errors        = 0;
    checked       = 0;
    cycles        = 0;
    current_idx   = 0;
    held_valid    = 1'b0;
    result_due    = 1'b0;
    num_tests     = 0;
    timeout_limit = 1000;
    load_tests();
    timeout_limit = 4 * num_tests + 50;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      send_uop(i);
    end
    while (exp_queue.size() != 0) begin
      @(posedge clk);
      #1;
    end
    // a few idle cycles catch any stray result
    repeat (3) @(posedge clk);
    finish_run();
  end

endmodule

//--- sim/alu_other_testdata.txt
# name rob funct3 funct6 vs1 vm vd_eew vs2_eew uop_index v0 vs1_data vs2_data rs1 exp_w_data exp_ignore_vma
# all fields hex, eew 0/1/2 = 8/16/32 bits, exp_w_data NONE for a uop with no result
vminu_vv8 1 0 04 0 1 0 0 0 0 0180ff020180ff020180ff020180ff02 807f01ff807f01ff807f01ff807f01ff 0 017f0102017f0102017f0102017f0102 0
vmin_vv16 2 0 05 0 1 1 1 0 0 0180ff020180ff020180ff020180ff02 807f01ff807f01ff807f01ff807f01ff 0 807fff02807fff02807fff02807fff02 0
vmaxu_vv32 3 0 06 0 1 2 2 0 0 0180ff020180ff020180ff020180ff02 807f01ff807f01ff807f01ff807f01ff 0 807f01ff807f01ff807f01ff807f01ff 0
vmax_vv16 4 0 07 0 1 1 1 0 0 0180ff020180ff020180ff020180ff02 807f01ff807f01ff807f01ff807f01ff 0 018001ff018001ff018001ff018001ff 0
vmin_vx8 5 4 05 0 1 0 0 0 0 0 807f01ff807f01ff807f01ff807f01ff 00000005 800501ff800501ff800501ff800501ff 0
vmaxu_vx16 6 4 06 0 1 1 1 0 0 0 807f01ff807f01ff807f01ff807f01ff 12348000 807f8000807f8000807f8000807f8000 0
vminu_vx32 7 4 04 0 1 2 2 0 0 0 807f01ff807f01ff807f01ff807f01ff 40000000 40000000400000004000000040000000 0
vmax_vx16 8 4 07 0 1 1 1 0 0 0 807f01ff807f01ff807f01ff807f01ff 0000ff00 ff0001ffff0001ffff0001ffff0001ff 0
vmv_vv 9 0 17 0 1 2 2 0 0 0123456789abcdeffedcba9876543210 807f01ff807f01ff807f01ff807f01ff 0 0123456789abcdeffedcba9876543210 0
vmv_vx16 a 4 17 0 1 1 2 0 0 0 807f01ff807f01ff807f01ff807f01ff 0000abcd abcdabcdabcdabcdabcdabcdabcdabcd 0
vmv_vi32 b 3 17 0 1 2 0 0 0 0 0 fffffff0 fffffff0fffffff0fffffff0fffffff0 0
vmin_vi_none c 3 05 0 1 0 0 0 0 0180ff020180ff020180ff020180ff02 807f01ff807f01ff807f01ff807f01ff 5 NONE 0
vmerge_i0_e8 d 0 17 0 0 0 0 0 ffff0000aaaa5555f0f00f0f00ff3c3c 22222222222222222222222222222222 11111111111111111111111111111111 0 11112222222211111111222222221111 1
vmerge_i5_e8 e 0 17 0 0 0 0 5 ffff0000aaaa5555f0f00f0f00ff3c3c 22222222222222222222222222222222 11111111111111111111111111111111 0 22112211221122112211221122112211 1
vmerge_i1_e16 f 0 17 0 0 1 1 1 ffff0000aaaa5555f0f00f0f00ff3c3c 22222222222222222222222222222222 11111111111111111111111111111111 0 11111111222222222222222211111111 1
vmerge_vx_i3_e32 0 4 17 0 0 2 2 3 ffff0000aaaa5555f0f00f0f00ff3c3c 0 11111111111111111111111111111111 deadbeef 1111111111111111deadbeefdeadbeef 1
vzext2_e8 1 2 12 06 1 1 0 2 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 00780069005a004b003c002d001e000f 0
vsext2_e8 2 2 12 07 1 1 0 1 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 fff0ffe1ffd2ffc3ffb4ffa5ff96ff87 0
vzext2_e16 3 2 12 06 1 2 1 1 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 0000f0e10000d2c30000b4a500009687 0
vsext2_e16 4 2 12 07 1 2 1 0 0 0 000000000000000080007fffffff0001 0 ffff800000007fffffffffff00000001 0
vzext4_e8 5 2 12 04 1 2 0 6 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 000000b4000000a50000009600000087 0
vext_bad_none 6 2 12 00 1 0 0 0 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 NONE 0
vsext4_e8 7 2 12 05 1 2 0 3 0 0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 fffffff0ffffffe1ffffffd2ffffffc3 0

//--- verilog.f
+incdir+verilog
verilog/alu_other_pkg.sv
verilog/alu_other_ctrl.sv
verilog/alu_operand_prep.sv
verilog/alu_minmax.sv
verilog/alu_extend.sv
verilog/alu_merge.sv
verilog/alu_other_top.sv
sim/tb_alu_other.sv
